// ==== Bender.yml ====
package:
  name: efpga_soc_bridge

sources:
  - common/efpga_pkg.sv
  - hw/tcdm/tcdm_port_slice.sv
  - hw/tcdm/tcdm_arbiter.sv
  - hw/control_filter.sv
  - hw/event_bridge.sv
  - hw/reg_access_gate.sv
  - hw/efpga_soc_bridge.sv
  - target: test
    files:
      - tb/efpga_soc_bridge_checker.sv
      - tb/efpga_soc_bridge_tb.sv

// ==== common/efpga_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, counts, bus structs and enums for
// the eFPGA SoC bridge; use through efpga_pkg::name
//////////////////////////////////////////////////

package efpga_pkg;

   localparam int num_ports       = 4;   // fabric memory ports
   localparam int local_addr_w    = 20;  // fabric side address
   localparam int soc_addr_w      = 32;
   localparam int data_w          = 32;
   localparam int be_w            = 4;
   localparam int num_events      = 8;
   localparam int max_outstanding = 4;   // tag queue depth
   localparam int gnt_delay       = 4;   // register grant delay in cycles

   // fixed upper bits of every fabric memory access
   localparam logic [soc_addr_w-local_addr_w-1:0] window_base = 12'h1C0;

   typedef logic [1:0] port_id_t;

   // fabric memory request, 57 bits
   typedef struct packed {
      logic                    wen;    // 1 = read
      logic [local_addr_w-1:0] addr;
      logic [be_w-1:0]         be;
      logic [data_w-1:0]       wdata;
   } fab_req_t;

   // SoC bus request, 69 bits
   typedef struct packed {
      logic                  wen;      // 1 = read
      logic [soc_addr_w-1:0] addr;
      logic [be_w-1:0]       be;
      logic [data_w-1:0]     wdata;
   } soc_req_t;

   // register access request, 57 bits
   typedef struct packed {
      logic                    wen;    // 1 = read
      logic [local_addr_w-1:0] addr;
      logic [be_w-1:0]         be;
      logic [data_w-1:0]       wdata;
   } reg_req_t;

   // encoding follows wen
   typedef enum logic {
      op_write = 1'b0,
      op_read  = 1'b1
   } bus_op_e;

   typedef enum logic {
      arb_idle = 1'b0,  // nothing waiting for grant
      arb_busy = 1'b1   // request on the bus
   } arb_state_e;

endpackage

// ==== files.f ====
common/efpga_pkg.sv
hw/tcdm/tcdm_port_slice.sv
hw/tcdm/tcdm_arbiter.sv
hw/control_filter.sv
hw/event_bridge.sv
hw/reg_access_gate.sv
hw/efpga_soc_bridge.sv
tb/efpga_soc_bridge_checker.sv
tb/efpga_soc_bridge_tb.sv

// ==== hw/control_filter.sv ====
//////////////////////////////////////////////////
// passes the control word to the fabric once it
// has been stable for three samples
//////////////////////////////////////////////////
`timescale 1ns/10ps

module control_filter (
   input  logic                          asic_clk_i,
   input  logic                          rst_n,
   input  logic [efpga_pkg::data_w-1:0]  control_i,
   output logic [efpga_pkg::data_w-1:0]  control_o
);

   logic [efpga_pkg::data_w-1:0] ctrl_d1;
   logic [efpga_pkg::data_w-1:0] ctrl_d2;
   logic                         stable;   // three equal samples seen

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_d1 <= '0;
         ctrl_d2 <= '0;
         stable  <= 1'b0;
      end else begin
         ctrl_d1 <= control_i;
         ctrl_d2 <= ctrl_d1;
         stable  <= (ctrl_d1 == control_i) && (ctrl_d2 == control_i);
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         control_o <= '0;
      end else if (stable) begin
         control_o <= ctrl_d1;
      end
   end

endmodule

// ==== hw/efpga_soc_bridge.sv ====
//////////////////////////////////////////////////
// SoC side bridge around the eFPGA fabric: memory
// ports on one bus, control, events, registers
//////////////////////////////////////////////////
`timescale 1ns/10ps

module efpga_soc_bridge (
   input  logic                                asic_clk_i,
   input  logic                                rst_n,
   input  logic [efpga_pkg::num_ports-1:0]     port_en_i,
   input  logic [efpga_pkg::num_ports-1:0]     fab_req_valid_i,
   input  efpga_pkg::fab_req_t                 fab_req_i [efpga_pkg::num_ports],
   output logic [efpga_pkg::num_ports-1:0]     fab_gnt_o,
   output logic [efpga_pkg::num_ports-1:0]     fab_rvalid_o,
   output logic [efpga_pkg::data_w-1:0]        fab_rdata_o [efpga_pkg::num_ports],
   output logic                                soc_req_o,
   output efpga_pkg::soc_req_t                 soc_req_data_o,
   input  logic                                soc_gnt_i,
   input  logic                                soc_rvalid_i,
   input  logic [efpga_pkg::data_w-1:0]        soc_rdata_i,
   input  logic [efpga_pkg::data_w-1:0]        control_i,
   output logic [efpga_pkg::data_w-1:0]        control_o,
   input  logic                                events_en_i,
   input  logic [efpga_pkg::num_events-1:0]    fab_event_i,
   output logic [efpga_pkg::num_events-1:0]    event_o,
   input  logic                                reg_en_i,
   input  logic                                reg_req_valid_i,
   input  efpga_pkg::reg_req_t                 reg_req_i,
   output logic                                reg_gnt_o,
   output logic                                reg_rvalid_o,
   output logic [efpga_pkg::data_w-1:0]        reg_rdata_o,
   output logic                                fab_reg_strobe_o,
   output efpga_pkg::reg_req_t                 fab_reg_req_o,
   input  logic                                fab_reg_gnt_i,
   input  logic                                fab_reg_rvalid_i,
   input  logic [efpga_pkg::data_w-1:0]        fab_reg_rdata_i
);

   logic [efpga_pkg::num_ports-1:0] pend_valid;
   efpga_pkg::soc_req_t             pend_req [efpga_pkg::num_ports];
   logic [efpga_pkg::num_ports-1:0] pend_taken;
   logic [efpga_pkg::num_ports-1:0] resp;          // per-port response strobe
   logic [efpga_pkg::data_w-1:0]    resp_rdata;

   for (genvar g = 0; g < efpga_pkg::num_ports; g++) begin : g_port
      tcdm_port_slice u_slice (
         .asic_clk_i      (asic_clk_i),
         .rst_n           (rst_n),
         .port_en_i       (port_en_i[g]),
         .fab_req_valid_i (fab_req_valid_i[g]),
         .fab_req_i       (fab_req_i[g]),
         .fab_gnt_o       (fab_gnt_o[g]),
         .fab_rvalid_o    (fab_rvalid_o[g]),
         .fab_rdata_o     (fab_rdata_o[g]),
         .pend_valid_o    (pend_valid[g]),
         .pend_req_o      (pend_req[g]),
         .pend_taken_i    (pend_taken[g]),
         .resp_i          (resp[g]),
         .resp_rdata_i    (resp_rdata)
      );
   end

   tcdm_arbiter u_arbiter (
      .asic_clk_i     (asic_clk_i),
      .rst_n          (rst_n),
      .pend_valid_i   (pend_valid),
      .pend_req_i     (pend_req),
      .pend_taken_o   (pend_taken),
      .resp_o         (resp),
      .resp_rdata_o   (resp_rdata),
      .soc_req_o      (soc_req_o),
      .soc_req_data_o (soc_req_data_o),
      .soc_gnt_i      (soc_gnt_i),
      .soc_rvalid_i   (soc_rvalid_i),
      .soc_rdata_i    (soc_rdata_i)
   );

   control_filter u_control_filter (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .control_i  (control_i),
      .control_o  (control_o)
   );

   event_bridge u_event_bridge (
      .asic_clk_i  (asic_clk_i),
      .rst_n       (rst_n),
      .events_en_i (events_en_i),
      .fab_event_i (fab_event_i),
      .event_o     (event_o)
   );

   reg_access_gate u_reg_access_gate (
      .asic_clk_i       (asic_clk_i),
      .rst_n            (rst_n),
      .reg_en_i         (reg_en_i),
      .reg_req_valid_i  (reg_req_valid_i),
      .reg_req_i        (reg_req_i),
      .reg_gnt_o        (reg_gnt_o),
      .reg_rvalid_o     (reg_rvalid_o),
      .reg_rdata_o      (reg_rdata_o),
      .fab_reg_strobe_o (fab_reg_strobe_o),
      .fab_reg_req_o    (fab_reg_req_o),
      .fab_reg_gnt_i    (fab_reg_gnt_i),
      .fab_reg_rvalid_i (fab_reg_rvalid_i),
      .fab_reg_rdata_i  (fab_reg_rdata_i)
   );

endmodule

// ==== hw/event_bridge.sv ====
//////////////////////////////////////////////////
// gates fabric events with an enable and turns
// each rising edge into a one-cycle SoC pulse
//////////////////////////////////////////////////
`timescale 1ns/10ps

module event_bridge (
   input  logic                               asic_clk_i,
   input  logic                               rst_n,
   input  logic                               events_en_i,
   input  logic [efpga_pkg::num_events-1:0]   fab_event_i,
   output logic [efpga_pkg::num_events-1:0]   event_o
);

   logic [efpga_pkg::num_events-1:0] event_gated;
   logic [efpga_pkg::num_events-1:0] event_q;   // previous gated level

   assign event_gated = fab_event_i & {efpga_pkg::num_events{events_en_i}};

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         event_q <= '0;
         event_o <= '0;
      end else begin
         event_q <= event_gated;
         event_o <= event_gated & ~event_q;   // rising edge only
      end
   end

endmodule

// ==== hw/reg_access_gate.sv ====
//////////////////////////////////////////////////
// SoC register access toward the fabric; strobes
// and delays grant when enabled, answers if not
//////////////////////////////////////////////////
`timescale 1ns/10ps

module reg_access_gate (
   input  logic                          asic_clk_i,
   input  logic                          rst_n,
   input  logic                          reg_en_i,
   input  logic                          reg_req_valid_i,
   input  efpga_pkg::reg_req_t           reg_req_i,
   output logic                          reg_gnt_o,
   output logic                          reg_rvalid_o,
   output logic [efpga_pkg::data_w-1:0]  reg_rdata_o,
   output logic                          fab_reg_strobe_o,
   output efpga_pkg::reg_req_t           fab_reg_req_o,
   input  logic                          fab_reg_gnt_i,
   input  logic                          fab_reg_rvalid_i,
   input  logic [efpga_pkg::data_w-1:0]  fab_reg_rdata_i
);

   // bit n set once the request has been held n+1 cycles
   logic [efpga_pkg::gnt_delay-1:0] req_hist;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         req_hist <= '0;
      end else if (!reg_en_i || !reg_req_valid_i || reg_gnt_o) begin
         req_hist <= '0;                           // start over when dropped or done
      end else begin
         req_hist <= {req_hist[efpga_pkg::gnt_delay-2:0], 1'b1};
      end
   end

   // first cycle of a request only
   assign fab_reg_strobe_o = reg_en_i & reg_req_valid_i & ~req_hist[0];
   assign fab_reg_req_o    = reg_req_i;

   always_comb begin
      if (reg_en_i) begin
         reg_gnt_o    = reg_req_valid_i & req_hist[efpga_pkg::gnt_delay-1] & fab_reg_gnt_i;
         reg_rvalid_o = fab_reg_rvalid_i;
         reg_rdata_o  = fab_reg_rdata_i;
      end else begin
         // fabric unused so answer at once
         reg_gnt_o    = reg_req_valid_i;
         reg_rvalid_o = 1'b1;
         reg_rdata_o  = '0;
      end
   end

endmodule

// ==== hw/tcdm/tcdm_arbiter.sv ====
//////////////////////////////////////////////////
// round-robin share of the SoC memory bus; a tag
// queue routes in-order responses to their port
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tcdm_arbiter (
   input  logic                                asic_clk_i,
   input  logic                                rst_n,
   input  logic [efpga_pkg::num_ports-1:0]     pend_valid_i,
   input  efpga_pkg::soc_req_t                 pend_req_i [efpga_pkg::num_ports],
   output logic [efpga_pkg::num_ports-1:0]     pend_taken_o,
   output logic [efpga_pkg::num_ports-1:0]     resp_o,
   output logic [efpga_pkg::data_w-1:0]        resp_rdata_o,
   output logic                                soc_req_o,
   output efpga_pkg::soc_req_t                 soc_req_data_o,
   input  logic                                soc_gnt_i,
   input  logic                                soc_rvalid_i,
   input  logic [efpga_pkg::data_w-1:0]        soc_rdata_i
);

   efpga_pkg::arb_state_e state;
   efpga_pkg::port_id_t   rr_ptr;      // first port to look at
   efpga_pkg::port_id_t   cur_port;    // owner of the request on the bus
   efpga_pkg::port_id_t   sel;
   logic                  found;
   logic                  load;
   logic                  push;
   logic                  pop;
   efpga_pkg::port_id_t   tag_mem [efpga_pkg::max_outstanding];
   logic [$clog2(efpga_pkg::max_outstanding)-1:0] wr_ptr;
   logic [$clog2(efpga_pkg::max_outstanding)-1:0] rd_ptr;
   logic [$clog2(efpga_pkg::max_outstanding):0]   tag_count;

   // search pending ports starting at rr_ptr
   always_comb begin
      efpga_pkg::port_id_t idx;
      sel   = rr_ptr;
      found = 1'b0;
      for (int k = 0; k < efpga_pkg::num_ports; k++) begin
         idx = rr_ptr + efpga_pkg::port_id_t'(k);
         if (pend_valid_i[idx] && !found) begin
            sel   = idx;
            found = 1'b1;
         end
      end
   end

   // no new request while every tag slot is taken
   assign load = (state == efpga_pkg::arb_idle) & found &
                 (tag_count < efpga_pkg::max_outstanding);

   always_comb begin
      pend_taken_o = '0;
      if (load) begin
         pend_taken_o[sel] = 1'b1;
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state    <= efpga_pkg::arb_idle;
         cur_port <= '0;
         rr_ptr   <= '0;
      end else begin
         case (state)
            efpga_pkg::arb_idle: if (load) begin
               state    <= efpga_pkg::arb_busy;
               cur_port <= sel;
            end
            efpga_pkg::arb_busy: if (soc_gnt_i) begin
               state  <= efpga_pkg::arb_idle;
               rr_ptr <= cur_port + 1'b1;   // next in line after the winner
            end
            default: state <= efpga_pkg::arb_idle;
         endcase
      end
   end

   always_ff @(posedge asic_clk_i) begin
      if (load) begin
         soc_req_data_o <= pend_req_i[sel];  // held until grant
      end
   end

   assign soc_req_o = (state == efpga_pkg::arb_busy);
   assign push      = soc_req_o & soc_gnt_i;
   assign pop       = soc_rvalid_i;

   always_ff @(posedge asic_clk_i) begin
      if (push) begin
         tag_mem[wr_ptr] <= cur_port;
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         tag_count <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   tag_count <= tag_count + 1'b1;
            2'b01:   tag_count <= tag_count - 1'b1;
            default: tag_count <= tag_count;
         endcase
      end
   end

   // oldest tag owns the response
   always_comb begin
      for (int i = 0; i < efpga_pkg::num_ports; i++) begin
         resp_o[i] = pop & (tag_mem[rd_ptr] == efpga_pkg::port_id_t'(i));
      end
   end

   assign resp_rdata_o = soc_rdata_i;

endmodule

// ==== hw/tcdm/tcdm_port_slice.sv ====
//////////////////////////////////////////////////
// one fabric memory port: holds a single request,
// widens its address and qualifies read responses
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tcdm_port_slice (
   input  logic                             asic_clk_i,
   input  logic                             rst_n,
   input  logic                             port_en_i,
   input  logic                             fab_req_valid_i,
   input  efpga_pkg::fab_req_t              fab_req_i,
   output logic                             fab_gnt_o,
   output logic                             fab_rvalid_o,
   output logic [efpga_pkg::data_w-1:0]     fab_rdata_o,
   output logic                             pend_valid_o,
   output efpga_pkg::soc_req_t              pend_req_o,
   input  logic                             pend_taken_i,
   input  logic                             resp_i,
   input  logic [efpga_pkg::data_w-1:0]     resp_rdata_i
);

   logic                hold_valid;
   efpga_pkg::fab_req_t hold_req;
   logic                in_flight;     // issued, response not back yet
   efpga_pkg::bus_op_e  last_op;

   // take a request only into an empty slot of an enabled port
   assign fab_gnt_o = port_en_i & fab_req_valid_i & ~hold_valid;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         hold_valid <= 1'b0;
      end else if (fab_gnt_o) begin
         hold_valid <= 1'b1;
      end else if (pend_taken_i) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge asic_clk_i) begin
      if (fab_gnt_o) begin
         hold_req <= fab_req_i;
      end
   end

   // one access per port on the bus, so last_op always matches the response
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         in_flight <= 1'b0;
         last_op   <= efpga_pkg::op_read;
      end else if (pend_taken_i) begin
         in_flight <= 1'b1;
         last_op   <= efpga_pkg::bus_op_e'(hold_req.wen);
      end else if (resp_i) begin
         in_flight <= 1'b0;
      end
   end

   assign pend_valid_o = hold_valid & ~in_flight;

   always_comb begin
      pend_req_o.wen   = hold_req.wen;
      pend_req_o.addr  = {efpga_pkg::window_base, hold_req.addr};  // SoC window
      pend_req_o.be    = hold_req.be;
      pend_req_o.wdata = hold_req.wdata;
   end

   // writes complete silently
   assign fab_rvalid_o = resp_i & (last_op == efpga_pkg::op_read);
   assign fab_rdata_o  = resp_rdata_i;

endmodule

// ==== tb/efpga_soc_bridge_checker.sv ====
//////////////////////////////////////////////////
// concurrent protocol checks for the bridge top,
// attached to every efpga_soc_bridge through bind
//////////////////////////////////////////////////
`timescale 1ns/10ps

module efpga_soc_bridge_checker (
   input logic                                asic_clk_i,
   input logic                                rst_n,
   input logic                                reg_en_i,
   input logic                                reg_req_valid_i,
   input logic                                reg_gnt_o,
   input logic [efpga_pkg::num_events-1:0]    event_o,
   input logic                                soc_req_o,
   input logic                                soc_gnt_i,
   input efpga_pkg::soc_req_t                 soc_req_data_o,
   input logic [efpga_pkg::num_ports-1:0]     port_en_i,
   input logic [efpga_pkg::num_ports-1:0]     fab_gnt_o
);

   a_reg_bypass: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      !reg_en_i |-> (reg_gnt_o == reg_req_valid_i))
      else $error("register grant differs from request while gate disabled");

   // no bit may stay high two cycles in a row
   a_event_pulse: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (event_o & $past(event_o)) == '0)
      else $error("event pulse longer than one cycle");

   a_req_hold: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (soc_req_o && !soc_gnt_i) |=> (soc_req_o && $stable(soc_req_data_o)))
      else $error("bus request changed before grant");

   a_port_off: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (fab_gnt_o & ~port_en_i) == '0)
      else $error("disabled port was granted");

endmodule

bind efpga_soc_bridge efpga_soc_bridge_checker u_checker (
   .asic_clk_i      (asic_clk_i),
   .rst_n           (rst_n),
   .reg_en_i        (reg_en_i),
   .reg_req_valid_i (reg_req_valid_i),
   .reg_gnt_o       (reg_gnt_o),
   .event_o         (event_o),
   .soc_req_o       (soc_req_o),
   .soc_gnt_i       (soc_gnt_i),
   .soc_req_data_o  (soc_req_data_o),
   .port_en_i       (port_en_i),
   .fab_gnt_o       (fab_gnt_o)
);

// ==== tb/efpga_soc_bridge_tb.sv ====
//////////////////////////////////////////////////
// testbench with SoC bus and fabric register models
// runs a stimulus table against the bridge top
//////////////////////////////////////////////////
`timescale 1ns/10ps

module efpga_soc_bridge_tb;

   localparam int tmo = 40;   // cycles per wait
   typedef enum {k_mem, k_par, k_dis, k_ctrl, k_evt, k_reg} kind_e;
   typedef struct {
      kind_e       kind;
      int          port;
      bit          rd;
      logic [19:0] addr;
      logic [31:0] data;
      bit          en;
   } stim_t;

   logic asic_clk_i, rst_n;
   logic [3:0] port_en_i, fab_req_valid_i, fab_gnt_o, fab_rvalid_o;
   efpga_pkg::fab_req_t fab_req_i [4];
   logic [31:0] fab_rdata_o [4];
   logic soc_req_o, soc_gnt_i, soc_rvalid_i;
   efpga_pkg::soc_req_t soc_req_data_o;
   logic [31:0] soc_rdata_i, control_i, control_o;
   logic events_en_i;
   logic [7:0] fab_event_i, event_o;
   logic reg_en_i, reg_req_valid_i, reg_gnt_o, reg_rvalid_o, fab_reg_strobe_o;
   efpga_pkg::reg_req_t reg_req_i, fab_reg_req_o;
   logic [31:0] reg_rdata_o, fab_reg_rdata_i;
   logic fab_reg_gnt_i, fab_reg_rvalid_i;

   logic [31:0] mem [logic [31:0]];       // bus model storage
   logic [31:0] exp_mem [logic [31:0]];   // what the testbench wrote
   logic [31:0] bus_log [$];
   logic [31:0] resp_data [$];
   int resp_due [$];
   int cyc, gnt_wait, bus_resp, granted, errors, checks;
   int rv_cnt [4];
   int ev_cnt [8];
   int strobe_cnt, reg_rv_cnt;
   logic strobe_seen;
   logic [31:0] reg_answer, reg_last;
   stim_t table_q [$];

   efpga_soc_bridge uut (.*);

   initial begin
      asic_clk_i = 1'b0;
      forever #20 asic_clk_i = ~asic_clk_i;
   end

   // SoC bus model with random grant delay and in-order answer two cycles after grant
   initial begin
      int seed;
      logic [31:0] a;
      seed = 2;
      void'($urandom(seed));
      forever begin
         @(negedge asic_clk_i);
         cyc++;
         soc_rvalid_i = 1'b0;
         if (resp_due.size() > 0 && resp_due[0] <= cyc) begin
            soc_rvalid_i = 1'b1;
            soc_rdata_i  = resp_data.pop_front();
            void'(resp_due.pop_front());
            bus_resp++;
         end
         if (soc_gnt_i) begin
            soc_gnt_i = 1'b0;
            gnt_wait  = $urandom % 3;
         end else if (soc_req_o) begin
            if (gnt_wait > 0) begin
               gnt_wait--;
            end else begin
               a = soc_req_data_o.addr;
               soc_gnt_i = 1'b1;
               bus_log.push_back(a);
               check("soc_req_data_o.be", soc_req_data_o.be, 4'hF);
               if (soc_req_data_o.wen) begin
                  resp_data.push_back(mem.exists(a) ? mem[a] : a);
               end else begin
                  mem[a] = soc_req_data_o.wdata;
                  resp_data.push_back('0);
               end
               resp_due.push_back(cyc + 2);
            end
         end
      end
   end

   // fabric register side answers one cycle after the strobe
   always @(negedge asic_clk_i) begin
      fab_reg_rvalid_i = strobe_seen;
      fab_reg_rdata_i  = reg_answer;
   end

   always @(posedge asic_clk_i) begin
      strobe_seen = fab_reg_strobe_o;
      if (fab_reg_strobe_o) begin
         reg_answer = 32'(fab_reg_req_o.addr) + 1;
         strobe_cnt++;
      end
      if (reg_en_i && reg_rvalid_o) begin
         reg_rv_cnt++;
         reg_last = reg_rdata_o;
      end
      for (int i = 0; i < 4; i++) if (fab_rvalid_o[i]) rv_cnt[i]++;
      for (int i = 0; i < 8; i++) if (event_o[i]) ev_cnt[i]++;
   end

   task automatic check(string name, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_problem(string what);
      $display("problem at t=%0t: %s", $time, what);
      errors++;
   endtask

   function automatic logic [31:0] expected_read(logic [31:0] a);
      return exp_mem.exists(a) ? exp_mem[a] : a;   // unwritten words read back their address
   endfunction

   task automatic mem_access(int p, bit rd, logic [19:0] addr, logic [31:0] wdata);
      int n;
      logic [31:0] soc_addr;
      soc_addr = {12'h1C0, addr};
      @(negedge asic_clk_i);
      fab_req_i[p] = '{wen: rd, addr: addr, be: 4'hF, wdata: wdata};
      fab_req_valid_i[p] = 1'b1;
      n = 0;
      do begin
         @(posedge asic_clk_i);
         n++;
      end while (!fab_gnt_o[p] && n < tmo);
      if (!fab_gnt_o[p]) report_problem($sformatf("port %0d was never granted", p));
      else granted++;
      @(negedge asic_clk_i);
      fab_req_valid_i[p] = 1'b0;
      if (!rd) exp_mem[soc_addr] = wdata;
      if (rd && n < tmo) begin
         n = 0;
         do begin
            @(posedge asic_clk_i);
            n++;
         end while (!fab_rvalid_o[p] && n < tmo);
         if (!fab_rvalid_o[p]) report_problem($sformatf("no read response on port %0d", p));
         else check($sformatf("fab_rdata_o[%0d]", p), fab_rdata_o[p], expected_read(soc_addr));
      end
   endtask

   // every granted fabric request answered by the bus
   task automatic drain_bus();
      int n;
      n = 0;
      while (bus_resp != granted && n < tmo) begin
         @(negedge asic_clk_i);
         n++;
      end
      if (bus_resp != granted) report_problem("bus responses missing");
      repeat (2) @(negedge asic_clk_i);
   endtask

   task automatic apply(stim_t s);
      int n;
      int mark;
      logic [31:0] prev;
      mark = bus_log.size();
      for (int i = 0; i < 4; i++) rv_cnt[i] = 0;
      case (s.kind)
         k_mem: mem_access(s.port, s.rd, s.addr, s.data);
         k_par: begin
            fork
               mem_access(0, s.data[0], s.addr, 32'hB000_0000);
               mem_access(1, s.data[1], s.addr + 20'h10, 32'hB000_0001);
               mem_access(2, s.data[2], s.addr + 20'h20, 32'hB000_0002);
               mem_access(3, s.data[3], s.addr + 20'h30, 32'hB000_0003);
            join
            drain_bus();
            for (int i = 0; i < 4; i++) check($sformatf("read count %0d", i), rv_cnt[i], s.data[i]);
         end
         k_dis: begin
            @(negedge asic_clk_i);
            port_en_i[s.port] = 1'b0;
            fab_req_i[s.port] = '{wen: 1'b1, addr: s.addr, be: 4'hF, wdata: '0};
            fab_req_valid_i[s.port] = 1'b1;
            repeat (tmo) begin
               @(posedge asic_clk_i);
               if (fab_gnt_o[s.port]) report_problem("disabled port got a grant");
            end
            @(negedge asic_clk_i);
            fab_req_valid_i[s.port] = 1'b0;
            port_en_i[s.port] = 1'b1;
            for (int i = mark; i < bus_log.size(); i++) begin
               if (bus_log[i] == {12'h1C0, s.addr}) report_problem("disabled port reached the bus");
            end
         end
         k_ctrl: begin
            prev = control_i;   // last word the filter has settled on
            @(negedge asic_clk_i);
            control_i = s.data;
            repeat (s.en ? 5 : 2) @(posedge asic_clk_i);
            @(negedge asic_clk_i);
            if (s.en) begin
               check("control_o", control_o, s.data);
            end else begin
               control_i = prev;
               repeat (8) begin
                  @(negedge asic_clk_i);
                  if (control_o == s.data) report_problem("short control glitch passed");
               end
               check("control_o", control_o, prev);
            end
         end
         k_evt: begin
            @(negedge asic_clk_i);
            events_en_i = s.en;
            fab_event_i = '0;
            @(negedge asic_clk_i);
            for (int i = 0; i < 8; i++) ev_cnt[i] = 0;
            fab_event_i = s.data[7:0];
            repeat (3) @(negedge asic_clk_i);
            fab_event_i = '0;
            repeat (3) @(negedge asic_clk_i);
            for (int i = 0; i < 8; i++) begin
               check($sformatf("event_o[%0d] pulses", i), ev_cnt[i], s.en & s.data[i]);
            end
         end
         k_reg: begin
            @(negedge asic_clk_i);
            reg_en_i   = s.en;
            strobe_cnt = 0;
            reg_rv_cnt = 0;
            reg_req_i  = '{wen: s.rd, addr: s.addr, be: 4'hF, wdata: s.data};
            reg_req_valid_i = 1'b1;
            if (!s.en) begin
               @(posedge asic_clk_i);
               check("reg_gnt_o", reg_gnt_o, 1);
               check("reg_rvalid_o", reg_rvalid_o, 1);
               check("reg_rdata_o", reg_rdata_o, 0);
               @(negedge asic_clk_i);
               reg_req_valid_i = 1'b0;
               @(posedge asic_clk_i);
               check("reg_gnt_o", reg_gnt_o, 0);
            end else begin
               n = 0;
               do begin
                  @(posedge asic_clk_i);
                  n++;
               end while (!reg_gnt_o && n < tmo);
               if (!reg_gnt_o) report_problem("register request never granted");
               else if (n <= 4) report_problem($sformatf("register grant after %0d cycles", n));
               check("fab_reg_req_o.wdata", fab_reg_req_o.wdata, s.data);
               @(negedge asic_clk_i);
               reg_req_valid_i = 1'b0;
               repeat (3) @(negedge asic_clk_i);
               check("fab_reg_strobe_o count", strobe_cnt, 1);
               check("reg_rvalid_o count", reg_rv_cnt, 1);
               check("reg_rdata_o", reg_last, 32'(s.addr) + 1);
            end
         end
         default: report_problem("unknown table entry");
      endcase
      if (s.kind == k_mem) drain_bus();
      for (int i = mark; i < bus_log.size(); i++) begin
         check("soc addr window", bus_log[i][31:20], 12'h1C0);
      end
   endtask

   initial begin
      int err0;
      rst_n = 1'b0;
      port_en_i = '1;
      fab_req_valid_i = '0;
      for (int i = 0; i < 4; i++) fab_req_i[i] = '0;
      soc_gnt_i = 1'b0;
      soc_rvalid_i = 1'b0;
      soc_rdata_i = '0;
      control_i = '0;
      events_en_i = 1'b0;
      fab_event_i = '0;
      reg_en_i = 1'b0;
      reg_req_valid_i = 1'b0;
      reg_req_i = '0;
      fab_reg_gnt_i = 1'b1;          // register side always ready
      fab_reg_rvalid_i = 1'b0;
      fab_reg_rdata_i = '0;
      strobe_seen = 1'b0;
      reg_answer = '0;
      for (int p = 0; p < 4; p++) begin
         table_q.push_back('{k_mem, p, 1'b0, 20'h01000 + 20'(p * 16), 32'hC0DE_0000 + p, 1'b1});
         table_q.push_back('{k_mem, p, 1'b1, 20'h01000 + 20'(p * 16), 32'h0, 1'b1});
      end
      table_q.push_back('{k_par, 0, 1'b0, 20'h01000, 32'h5, 1'b1});   // ports 0,2 read
      table_q.push_back('{k_par, 0, 1'b0, 20'h02000, 32'hF, 1'b1});   // unwritten words
      table_q.push_back('{k_dis, 2, 1'b1, 20'h0BEEF, 32'h0, 1'b0});
      table_q.push_back('{k_ctrl, 0, 1'b0, 20'h0, 32'h1234_5678, 1'b1});
      table_q.push_back('{k_ctrl, 0, 1'b0, 20'h0, 32'hDEAD_0001, 1'b0});
      table_q.push_back('{k_evt, 0, 1'b0, 20'h0, 32'hA5, 1'b1});
      table_q.push_back('{k_evt, 0, 1'b0, 20'h0, 32'hFF, 1'b0});
      table_q.push_back('{k_reg, 0, 1'b1, 20'h00040, 32'h0, 1'b0});
      table_q.push_back('{k_reg, 0, 1'b1, 20'h00ABC, 32'h0000_5A5A, 1'b1});
      repeat (10) @(posedge asic_clk_i);
      @(negedge asic_clk_i);
      rst_n = 1'b1;
      for (int i = 0; i < table_q.size(); i++) begin
         err0 = errors;
         apply(table_q[i]);
         $display("test %0d %s: %s", i, table_q[i].kind.name(), errors == err0 ? "ok" : "errors");
      end
      $display("%0d tests, %0d checks, %0d errors", table_q.size(), checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
